//--- hdl/cnu_pkg.sv
// widths, lane counts, credit depths and vector types of the check-node unit
package cnu_pkg;

	// message format
	localparam int CN_DEGREE = 10;
	localparam int QUAN_SIZE = 4;
	localparam int MAG_SIZE  = 3;
	localparam int IDX_SIZE  = $clog2(CN_DEGREE);

	// flow control
	localparam int QUEUE_DEPTH = 4;
	localparam int OUT_CREDITS = 2;

	// queue bookkeeping widths
	localparam int QPTR_SIZE = $clog2(QUEUE_DEPTH);
	localparam int QCNT_SIZE = $clog2(QUEUE_DEPTH + 1);
	localparam int CRED_SIZE = $clog2(OUT_CREDITS + 1);

	// one coded message, bit 3 is the sign
	typedef logic [QUAN_SIZE-1:0] msg_t;

	// decoded magnitude
	typedef logic [MAG_SIZE-1:0] mag_t;

	// lane number within a row
	typedef logic [IDX_SIZE-1:0] idx_t;

	// full row, lane 0 in the low bits
	typedef logic [CN_DEGREE*QUAN_SIZE-1:0] row_t;

	// magnitudes of a row, same lane order
	typedef logic [CN_DEGREE*MAG_SIZE-1:0] mag_row_t;

	// one sign bit per lane
	typedef logic [CN_DEGREE-1:0] sign_row_t;

endpackage

//--- hdl/cnu_sign_mag.sv
// stage 0 with extrinsic sign product, magnitude decode and first pipeline register
`timescale 1ns/1ps

module cnu_sign_mag import cnu_pkg::*; (
	input  logic      sys_clk,
	input  logic      rstn,
	input  logic      in_valid_i,
	input  row_t      var_to_ch_i,
	output logic      s0_valid_o,
	output sign_row_t s0_signs_o,
	output mag_row_t  s0_mags_o
);

	sign_row_t in_signs;
	sign_row_t ext_signs;
	mag_row_t  in_mags;
	logic      parity;

	// split lanes into sign and magnitude
	always_comb begin
		msg_t lane;
		for (int i = 0; i < CN_DEGREE; i++) begin
			lane = var_to_ch_i[i*QUAN_SIZE +: QUAN_SIZE];
			in_signs[i] = lane[QUAN_SIZE-1];
			// positive messages carry the magnitude inverted
			in_mags[i*MAG_SIZE +: MAG_SIZE] = lane[MAG_SIZE-1:0] ^ {MAG_SIZE{~lane[QUAN_SIZE-1]}};
		end
	end

	assign parity = ^in_signs;

	// xor own sign back out of the full product
	assign ext_signs = in_signs ^ {CN_DEGREE{parity}};

	always_ff @(posedge sys_clk) begin
		if (!rstn) begin
			s0_valid_o <= 1'b0;
		end else begin
			s0_valid_o <= in_valid_i;
		end
	end

	// payload follows valid
	always_ff @(posedge sys_clk) begin
		s0_signs_o <= ext_signs;
		s0_mags_o  <= in_mags;
	end

endmodule

//--- hdl/cnu_min_search.sv
// stage 1 with two-minimum search, min1 lane index and second pipeline register
`timescale 1ns/1ps

module cnu_min_search import cnu_pkg::*; (
	input  logic      sys_clk,
	input  logic      rstn,
	input  logic      s0_valid_i,
	input  sign_row_t s0_signs_i,
	input  mag_row_t  s0_mags_i,
	output logic      s1_valid_o,
	output sign_row_t s1_signs_o,
	output mag_t      s1_min1_o,
	output mag_t      s1_min2_o,
	output idx_t      s1_min1_idx_o
);

	mag_t min1;
	mag_t min2;
	idx_t min1_idx;

	// first pass finds min1, strict compare keeps the lowest lane
	always_comb begin
		mag_t m;
		min1     = '1;
		min1_idx = '0;
		for (int i = 0; i < CN_DEGREE; i++) begin
			m = s0_mags_i[i*MAG_SIZE +: MAG_SIZE];
			if (m < min1) begin
				min1     = m;
				min1_idx = idx_t'(i);
			end
		end
	end

	// second pass skips only the min1 lane, so ties give min2 == min1
	always_comb begin
		mag_t m;
		min2 = '1;
		for (int i = 0; i < CN_DEGREE; i++) begin
			m = s0_mags_i[i*MAG_SIZE +: MAG_SIZE];
			if (idx_t'(i) != min1_idx && m < min2) begin
				min2 = m;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!rstn) begin
			s1_valid_o <= 1'b0;
		end else begin
			s1_valid_o <= s0_valid_i;
		end
	end

	always_ff @(posedge sys_clk) begin
		s1_signs_o    <= s0_signs_i;
		s1_min1_o     <= min1;
		s1_min2_o     <= min2;
		s1_min1_idx_o <= min1_idx;
	end

	a_min_order: assert property (@(posedge sys_clk) disable iff (!rstn)
		s1_valid_o |-> s1_min1_o <= s1_min2_o);

	a_idx_range: assert property (@(posedge sys_clk) disable iff (!rstn)
		s1_valid_o |-> s1_min1_idx_o < CN_DEGREE);

endmodule

//--- hdl/cnu_msg_gen.sv
// stage 2 with per-lane magnitude select, offset re-encoding and output register
`timescale 1ns/1ps

module cnu_msg_gen import cnu_pkg::*; (
	input  logic      sys_clk,
	input  logic      rstn,
	input  logic      s1_valid_i,
	input  sign_row_t s1_signs_i,
	input  mag_t      s1_min1_i,
	input  mag_t      s1_min2_i,
	input  idx_t      s1_min1_idx_i,
	output logic      s2_valid_o,
	output row_t      s2_row_o
);

	row_t row;

	always_comb begin
		mag_t mag;
		logic sign;
		for (int i = 0; i < CN_DEGREE; i++) begin
			sign = s1_signs_i[i];
			// min1 lane must not see its own magnitude
			mag = (s1_min1_idx_i == idx_t'(i)) ? s1_min2_i : s1_min1_i;
			row[i*QUAN_SIZE +: QUAN_SIZE] = msg_t'({sign, mag ^ {MAG_SIZE{~sign}}});
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!rstn) begin
			s2_valid_o <= 1'b0;
		end else begin
			s2_valid_o <= s1_valid_i;
		end
	end

	always_ff @(posedge sys_clk) begin
		s2_row_o <= row;
	end

endmodule

//--- hdl/cnu_out_queue.sv
// output row queue with output-credit counter and input credit return
`timescale 1ns/1ps

module cnu_out_queue import cnu_pkg::*; (
	input  logic sys_clk,
	input  logic rstn,
	input  logic s2_valid_i,
	input  row_t s2_row_i,
	input  logic out_credit_i,
	output logic out_valid_o,
	output row_t ch_to_var_o,
	output logic in_credit_o
);

	row_t                 mem [QUEUE_DEPTH];
	logic [QPTR_SIZE-1:0] wr_ptr;
	logic [QPTR_SIZE-1:0] rd_ptr;
	logic [QCNT_SIZE-1:0] fill;
	logic [CRED_SIZE-1:0] credits;
	logic                 push;
	logic                 pop;

	function automatic logic [QPTR_SIZE-1:0] next_ptr(input logic [QPTR_SIZE-1:0] p);
		return (p == QPTR_SIZE'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	// stages never stall, so every valid row is written
	assign push = s2_valid_i;
	assign pop  = (fill != '0) && (credits != '0);

	always_ff @(posedge sys_clk) begin
		if (push) begin
			mem[wr_ptr] <= s2_row_i;
		end
		if (pop) begin
			ch_to_var_o <= mem[rd_ptr];
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end else begin
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({push, pop})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
		end
	end

	// pop spends a credit, downstream return adds one back
	always_ff @(posedge sys_clk) begin
		if (!rstn) begin
			credits     <= CRED_SIZE'(OUT_CREDITS);
			out_valid_o <= 1'b0;
			in_credit_o <= 1'b0;
		end else begin
			case ({pop, out_credit_i})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
			out_valid_o <= pop;
			in_credit_o <= pop;
		end
	end

	// upstream credits keep the pipeline plus queue within QUEUE_DEPTH rows
	a_no_overflow: assert property (@(posedge sys_clk) disable iff (!rstn)
		push |-> fill != QCNT_SIZE'(QUEUE_DEPTH));

	a_credit_bound: assert property (@(posedge sys_clk) disable iff (!rstn)
		credits <= CRED_SIZE'(OUT_CREDITS));

	a_pop_credit: assert property (@(posedge sys_clk) disable iff (!rstn)
		out_valid_o |-> $past(credits) != '0);

endmodule

//--- hdl/cnu_top.sv
// check-node unit top with three pipeline stages and the credit-managed output queue
`timescale 1ns/1ps

module cnu_top import cnu_pkg::*; (
	input  logic sys_clk,
	input  logic rstn,
	input  logic in_valid_i,
	input  row_t var_to_ch_i,
	input  logic out_credit_i,
	output logic out_valid_o,
	output row_t ch_to_var_o,
	output logic in_credit_o
);

	logic      s0_valid;
	sign_row_t s0_signs;
	mag_row_t  s0_mags;

	logic      s1_valid;
	sign_row_t s1_signs;
	mag_t      s1_min1;
	mag_t      s1_min2;
	idx_t      s1_min1_idx;

	logic      s2_valid;
	row_t      s2_row;

	cnu_sign_mag u_sign_mag (
		.sys_clk     (sys_clk),
		.rstn        (rstn),
		.in_valid_i  (in_valid_i),
		.var_to_ch_i (var_to_ch_i),
		.s0_valid_o  (s0_valid),
		.s0_signs_o  (s0_signs),
		.s0_mags_o   (s0_mags)
	);

	cnu_min_search u_min_search (
		.sys_clk       (sys_clk),
		.rstn          (rstn),
		.s0_valid_i    (s0_valid),
		.s0_signs_i    (s0_signs),
		.s0_mags_i     (s0_mags),
		.s1_valid_o    (s1_valid),
		.s1_signs_o    (s1_signs),
		.s1_min1_o     (s1_min1),
		.s1_min2_o     (s1_min2),
		.s1_min1_idx_o (s1_min1_idx)
	);

	cnu_msg_gen u_msg_gen (
		.sys_clk       (sys_clk),
		.rstn          (rstn),
		.s1_valid_i    (s1_valid),
		.s1_signs_i    (s1_signs),
		.s1_min1_i     (s1_min1),
		.s1_min2_i     (s1_min2),
		.s1_min1_idx_i (s1_min1_idx),
		.s2_valid_o    (s2_valid),
		.s2_row_o      (s2_row)
	);

	cnu_out_queue u_out_queue (
		.sys_clk      (sys_clk),
		.rstn         (rstn),
		.s2_valid_i   (s2_valid),
		.s2_row_i     (s2_row),
		.out_credit_i (out_credit_i),
		.out_valid_o  (out_valid_o),
		.ch_to_var_o  (ch_to_var_o),
		.in_credit_o  (in_credit_o)
	);

endmodule

//--- sim/cnu_ref_model.svh
// offset-code helpers, row builder and expected check-node output row
`ifndef CNU_REF_MODEL_SVH
`define CNU_REF_MODEL_SVH

function automatic msg_t lane_msg(input row_t r, input int i);
	return r[i*QUAN_SIZE +: QUAN_SIZE];
endfunction

// sign 1 keeps bits 2:0 as they are, sign 0 stores them inverted
function automatic mag_t decode_mag(input msg_t m);
	return m[QUAN_SIZE-1] ? m[MAG_SIZE-1:0] : ~m[MAG_SIZE-1:0];
endfunction

function automatic msg_t encode_msg(input logic s, input mag_t mag);
	return s ? {1'b1, mag} : {1'b0, ~mag};
endfunction

function automatic row_t build_row(input sign_row_t s, input mag_row_t m);
	row_t r;
	for (int i = 0; i < CN_DEGREE; i++) begin
		r[i*QUAN_SIZE +: QUAN_SIZE] = encode_msg(s[i], m[i*MAG_SIZE +: MAG_SIZE]);
	end
	return r;
endfunction

// each lane sees only the other nine lanes
function automatic row_t expected_row(input row_t r);
	row_t res;
	logic s;
	mag_t mn;
	msg_t m;
	res = '0;
	for (int i = 0; i < CN_DEGREE; i++) begin
		s  = 1'b0;
		mn = '1;
		for (int j = 0; j < CN_DEGREE; j++) begin
			if (j != i) begin
				m = lane_msg(r, j);
				s = s ^ m[QUAN_SIZE-1];
				if (decode_mag(m) < mn) begin
					mn = decode_mag(m);
				end
			end
		end
		res[i*QUAN_SIZE +: QUAN_SIZE] = encode_msg(s, mn);
	end
	return res;
endfunction

`endif

//--- sim/cnu_tb.sv
// testbench for the check-node unit with credit bookkeeping and directed tests
`timescale 1ns/1ps

module cnu_tb import cnu_pkg::*; ();

	localparam int TIMEOUT = 200;

	logic   sys_clk;
	logic   rstn;
	logic   in_valid_i;
	row_t   var_to_ch_i;
	logic   out_credit_i;
	logic   out_valid_o;
	row_t   ch_to_var_o;
	logic   in_credit_o;

	integer seed;
	int     errors;
	int     checks;
	int     credits;
	int     credit_pulses;
	int     out_count;
	int     owed;
	logic   auto_credit;
	row_t   exp_q[$];

	`include "cnu_ref_model.svh"

	cnu_top dut (
		.sys_clk      (sys_clk),
		.rstn         (rstn),
		.in_valid_i   (in_valid_i),
		.var_to_ch_i  (var_to_ch_i),
		.out_credit_i (out_credit_i),
		.out_valid_o  (out_valid_o),
		.ch_to_var_o  (ch_to_var_o),
		.in_credit_o  (in_credit_o)
	);

	always #10 sys_clk = ~sys_clk;

	task automatic check_value(input string name, input logic [63:0] want, input logic [63:0] got);
		checks++;
		assert (got === want) else begin
			$display("[ERROR] %s expected %0h got %0h", name, want, got);
			errors++;
		end
	endtask

	task automatic check_row(input row_t got);
		row_t want;
		assert (exp_q.size() != 0) else begin
			$display("an output row arrived while no row was outstanding");
			errors++;
		end
		if (exp_q.size() != 0) begin
			want = exp_q.pop_front();
			for (int i = 0; i < CN_DEGREE; i++) begin
				check_value($sformatf("lane %0d ch_to_var_o", i),
					lane_msg(want, i), lane_msg(got, i));
			end
		end
	endtask

	// outputs as registered on the previous edge
	always @(posedge sys_clk) begin
		if (rstn) begin
			if (in_credit_o) begin
				credits++;
				credit_pulses++;
			end
			if (out_valid_o) begin
				out_count++;
				owed++;
				check_row(ch_to_var_o);
			end
		end
	end

	// downstream hands back one credit per cycle while allowed
	always @(negedge sys_clk) begin
		if (auto_credit && owed > 0) begin
			out_credit_i = 1'b1;
			owed--;
		end else begin
			out_credit_i = 1'b0;
		end
	end

	task automatic send_row(input row_t r);
		int t;
		t = 0;
		@(negedge sys_clk);
		in_valid_i = 1'b0;
		while (credits == 0 && t < TIMEOUT) begin
			@(negedge sys_clk);
			t++;
		end
		assert (credits != 0) else begin
			$display("timed out waiting for an input credit");
			errors++;
		end
		if (credits != 0) begin
			in_valid_i  = 1'b1;
			var_to_ch_i = r;
			credits--;
			exp_q.push_back(expected_row(r));
		end
	endtask

	task automatic wait_drain();
		int t;
		t = 0;
		@(negedge sys_clk);
		in_valid_i = 1'b0;
		while ((exp_q.size() != 0 || owed != 0) && t < TIMEOUT) begin
			@(negedge sys_clk);
			t++;
		end
		assert (exp_q.size() == 0 && owed == 0) else begin
			$display("timed out with %0d rows still inside the unit", exp_q.size());
			errors++;
		end
		check_value("upstream credits", QUEUE_DEPTH, credits);
	endtask

	task automatic test_reset();
		rstn = 1'b0;
		repeat (4) begin
			@(negedge sys_clk);
			check_value("out_valid_o in reset", 0, out_valid_o);
			check_value("in_credit_o in reset", 0, in_credit_o);
		end
		rstn = 1'b1;
		repeat (6) begin
			@(negedge sys_clk);
			check_value("out_valid_o after reset", 0, out_valid_o);
			check_value("in_credit_o after reset", 0, in_credit_o);
		end
	endtask

	task automatic test_single_row();
		send_row(build_row(10'b1011001010,
			{3'd6, 3'd3, 3'd7, 3'd1, 3'd4, 3'd6, 3'd2, 3'd7, 3'd3, 3'd5}));
		wait_drain();
	endtask

	task automatic test_extremes();
		mag_row_t uniq;
		uniq = {CN_DEGREE{3'd5}};
		uniq[7*MAG_SIZE +: MAG_SIZE] = 3'd2;
		send_row(build_row(10'b0101100110, '0));
		send_row(build_row(10'b1100011001, '1));
		send_row(build_row('1, {3'd1, 3'd4, 3'd7, 3'd2, 3'd5, 3'd3, 3'd6, 3'd0, 3'd4, 3'd2}));
		send_row(build_row('0, {3'd3, 3'd6, 3'd1, 3'd5, 3'd2, 3'd7, 3'd0, 3'd4, 3'd6, 3'd3}));
		// lane 7 alone holds the minimum
		send_row(build_row(10'b1001110100, uniq));
		wait_drain();
	endtask

	task automatic test_random_stream();
		row_t r;
		int   lo;
		int   j;
		int   base_pulses;
		int   base_out;
		base_pulses = credit_pulses;
		base_out    = out_count;
		for (int n = 0; n < 50; n++) begin
			r = row_t'({$random(seed), $random(seed)});
			// copy the minimum into a second lane to force a tie
			if (n % 4 == 0) begin
				lo = 0;
				for (int i = 1; i < CN_DEGREE; i++) begin
					if (decode_mag(lane_msg(r, i)) < decode_mag(lane_msg(r, lo))) begin
						lo = i;
					end
				end
				j = (lo + 1 + (($random(seed) & 32'hff) % (CN_DEGREE - 1))) % CN_DEGREE;
				r[j*QUAN_SIZE +: QUAN_SIZE] =
					encode_msg(1'($random(seed)), decode_mag(lane_msg(r, lo)));
			end
			send_row(r);
		end
		wait_drain();
		check_value("in_credit_o pulses", 50, credit_pulses - base_pulses);
		check_value("rows delivered", 50, out_count - base_out);
	endtask

	task automatic test_backpressure();
		int base_out;
		int t;
		auto_credit = 1'b0;
		base_out    = out_count;
		for (int n = 0; n < QUEUE_DEPTH; n++) begin
			send_row(row_t'({$random(seed), $random(seed)}));
		end
		@(negedge sys_clk);
		in_valid_i = 1'b0;
		t = 0;
		while (out_count - base_out < OUT_CREDITS && t < TIMEOUT) begin
			@(negedge sys_clk);
			t++;
		end
		assert (out_count - base_out >= OUT_CREDITS) else begin
			$display("timed out waiting for the first rows under back-pressure");
			errors++;
		end
		repeat (40) @(negedge sys_clk);
		check_value("outputs without credit", OUT_CREDITS, out_count - base_out);
		auto_credit = 1'b1;
		wait_drain();
		check_value("rows delivered", QUEUE_DEPTH, out_count - base_out);
	endtask

	initial begin
		seed          = 32'h9adf3e60;
		sys_clk       = 1'b0;
		rstn          = 1'b0;
		in_valid_i    = 1'b0;
		var_to_ch_i   = '0;
		out_credit_i  = 1'b0;
		errors        = 0;
		checks        = 0;
		credits       = QUEUE_DEPTH;
		credit_pulses = 0;
		out_count     = 0;
		owed          = 0;
		auto_credit   = 1'b1;
		test_reset();
		test_single_row();
		test_extremes();
		test_random_stream();
		test_backpressure();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

//--- cnu.f
+incdir+sim
hdl/cnu_pkg.sv
hdl/cnu_sign_mag.sv
hdl/cnu_min_search.sv
hdl/cnu_msg_gen.sv
hdl/cnu_out_queue.sv
hdl/cnu_top.sv
sim/cnu_tb.sv

//--- Bender.yml
package:
  name: cnu

sources:
  - hdl/cnu_pkg.sv
  - hdl/cnu_sign_mag.sv
  - hdl/cnu_min_search.sv
  - hdl/cnu_msg_gen.sv
  - hdl/cnu_out_queue.sv
  - hdl/cnu_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/cnu_tb.sv
